// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cpu_tb
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: hdl/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// ====================
// core geometry
// ====================
`define CPU_RESET_PC  32'h3000_0000
`define CPU_XLEN      32
`define CPU_REG_COUNT 16

// major opcodes, inst[6:0]
`define CPU_OPC_OP     7'b0110011
`define CPU_OPC_OP_IMM 7'b0010011
`define CPU_OPC_LOAD   7'b0000011
`define CPU_OPC_STORE  7'b0100011
`define CPU_OPC_LUI    7'b0110111
`define CPU_OPC_JALR   7'b1100111

// funct3, inst[14:12]
`define CPU_F3_ADD 3'b000
`define CPU_F3_LW  3'b010
`define CPU_F3_LBU 3'b100
`define CPU_F3_SW  3'b010
`define CPU_F3_SB  3'b000

`endif

// File: hdl/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

  // ====================
  // shared vector types
  // ====================
  typedef logic [`CPU_XLEN-1:0] word_t;

  // index as encoded in the instruction, rf only looks at [3:0]
  typedef logic [4:0] reg_idx_t;

  typedef logic [3:0] byte_mask_t;

  // bus size code: 0 byte, 2 word
  typedef logic [1:0] access_size_t;

  // decoded instruction kind
  typedef enum logic [3:0] {
    KIND_NOP,
    KIND_ADD,
    KIND_ADDI,
    KIND_LUI,
    KIND_JALR,
    KIND_LW,
    KIND_LBU,
    KIND_SW,
    KIND_SB
  } inst_kind_e;

endpackage

// File: hdl/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
  input  logic                  clk,
  input  logic                  rst,
  output logic                  ifu_req,
  output cpu_pkg::word_t        ifu_addr,
  input  logic                  ifu_resp,
  input  cpu_pkg::word_t        ifu_rdata,
  output logic                  lsu_req,
  output cpu_pkg::word_t        lsu_addr,
  output logic                  lsu_wen,
  output cpu_pkg::word_t        lsu_wdata,
  output cpu_pkg::byte_mask_t   lsu_wmask,
  output cpu_pkg::access_size_t lsu_size,
  input  logic                  lsu_resp,
  input  cpu_pkg::word_t        lsu_rdata
);

  import cpu_pkg::*;

  // ====================
  // internal nets
  // ====================
  word_t        pc;
  word_t        inst;
  logic         inst_valid;
  word_t        next_pc;
  inst_kind_e   kind;
  reg_idx_t     rs1;
  reg_idx_t     rs2;
  reg_idx_t     rd;
  word_t        imm;
  byte_mask_t   wmask;
  access_size_t size;
  word_t        rdata_1;
  word_t        rdata_2;
  word_t        alu_out;
  logic         mem_start;
  logic         mem_done;
  word_t        load_data;
  logic         retire;
  logic         reg_wen;
  word_t        reg_wdata;

  fetch_unit u_fetch (
    .clk, .rst, .retire, .next_pc, .pc, .inst, .inst_valid,
    .ifu_req, .ifu_addr, .ifu_resp, .ifu_rdata
  );

  decoder u_decoder (
    .inst, .kind, .rs1, .rs2, .rd, .imm, .wmask, .size
  );

  register_file u_regs (
    .clk, .wen(reg_wen), .waddr(rd), .wdata(reg_wdata),
    .raddr_1(rs1), .raddr_2(rs2), .rdata_1, .rdata_2
  );

  execute_unit u_execute (
    .kind, .pc, .rdata_1, .rdata_2, .imm, .alu_out, .next_pc
  );

  // store data is rs2 straight from the register file
  load_store_unit u_lsu (
    .clk, .rst, .mem_start, .kind, .addr(alu_out), .store_data(rdata_2),
    .wmask, .size, .mem_done, .load_data,
    .lsu_req, .lsu_addr, .lsu_wen, .lsu_wdata, .lsu_wmask, .lsu_size,
    .lsu_resp, .lsu_rdata
  );

  retire_unit u_retire (
    .clk, .rst, .inst_valid, .kind, .pc, .alu_out, .load_data, .mem_done,
    .mem_start, .retire, .reg_wen, .reg_wdata
  );

endmodule

// File: hdl/decoder.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module decoder (
  input  cpu_pkg::word_t        inst,
  output cpu_pkg::inst_kind_e   kind,
  output cpu_pkg::reg_idx_t     rs1,
  output cpu_pkg::reg_idx_t     rs2,
  output cpu_pkg::reg_idx_t     rd,
  output cpu_pkg::word_t        imm,
  output cpu_pkg::byte_mask_t   wmask,
  output cpu_pkg::access_size_t size
);

  import cpu_pkg::*;

  localparam access_size_t SIZE_BYTE = 2'd0;
  localparam access_size_t SIZE_WORD = 2'd2;

  logic [6:0] opcode;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_u;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  // ====================
  // immediates
  // ====================
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'b0};

  always_comb begin
    kind  = KIND_NOP;
    imm   = '0;
    wmask = '0;
    size  = SIZE_BYTE;
    case (opcode)
      `CPU_OPC_OP: begin
        if (funct3 == `CPU_F3_ADD) kind = KIND_ADD;
      end
      `CPU_OPC_OP_IMM: begin
        if (funct3 == `CPU_F3_ADD) begin
          kind = KIND_ADDI;
          imm  = imm_i;
        end
      end
      `CPU_OPC_LUI: begin
        kind = KIND_LUI;
        imm  = imm_u;
      end
      `CPU_OPC_JALR: begin
        kind = KIND_JALR;
        imm  = imm_i;
      end
      `CPU_OPC_LOAD: begin
        imm = imm_i;
        if (funct3 == `CPU_F3_LW) begin
          kind  = KIND_LW;
          wmask = 4'b1111;
          size  = SIZE_WORD;
        end else if (funct3 == `CPU_F3_LBU) begin
          kind  = KIND_LBU;
          wmask = 4'b0001;
        end
      end
      `CPU_OPC_STORE: begin
        imm = imm_s;
        if (funct3 == `CPU_F3_SW) begin
          kind  = KIND_SW;
          wmask = 4'b1111;
          size  = SIZE_WORD;
        end else if (funct3 == `CPU_F3_SB) begin
          kind  = KIND_SB;
          wmask = 4'b0001;
        end
      end
      // anything else retires as a nop
      default: kind = KIND_NOP;
    endcase
  end

endmodule

// File: hdl/execute_unit.sv
`timescale 1ns/100ps

module execute_unit (
  input  cpu_pkg::inst_kind_e kind,
  input  cpu_pkg::word_t      pc,
  input  cpu_pkg::word_t      rdata_1,
  input  cpu_pkg::word_t      rdata_2,
  input  cpu_pkg::word_t      imm,
  output cpu_pkg::word_t      alu_out,
  output cpu_pkg::word_t      next_pc
);

  import cpu_pkg::*;

  word_t op_a;
  word_t op_b;

  // ====================
  // operand select
  // ====================
  // lui adds its immediate to zero
  assign op_a = (kind == KIND_LUI) ? '0 : rdata_1;
  // only register-register add takes rs2
  assign op_b = (kind == KIND_ADD) ? rdata_2 : imm;

  // also the load/store address
  assign alu_out = op_a + op_b;

  // jalr target has bit 0 cleared
  assign next_pc = (kind == KIND_JALR) ? {alu_out[31:1], 1'b0} : pc + 32'd4;

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module fetch_unit (
  input  logic           clk,
  input  logic           rst,
  input  logic           retire,
  input  cpu_pkg::word_t next_pc,
  output cpu_pkg::word_t pc,
  output cpu_pkg::word_t inst,
  output logic           inst_valid,
  output logic           ifu_req,
  output cpu_pkg::word_t ifu_addr,
  input  logic           ifu_resp,
  input  cpu_pkg::word_t ifu_rdata
);

  typedef enum logic {FETCH_IDLE, FETCH_WAIT} fetch_state_e;

  fetch_state_e state;
  // first fetch after reset has no retire to trigger it
  logic boot;
  // bus view, set by a request and cleared by its response
  logic fetch_pending;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `CPU_RESET_PC;
    end else if (retire) begin
      pc <= next_pc;
    end
  end

  // pc already holds the new value when the request goes out
  assign ifu_addr = pc;

  // ====================
  // fetch fsm
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= FETCH_IDLE;
      boot       <= 1'b1;
      ifu_req    <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      ifu_req <= 1'b0;
      case (state)
        FETCH_IDLE: begin
          if (retire) begin
            inst_valid <= 1'b0;
          end
          if (boot || retire) begin
            boot    <= 1'b0;
            ifu_req <= 1'b1;
            state   <= FETCH_WAIT;
          end
        end
        FETCH_WAIT: begin
          if (ifu_resp) begin
            inst_valid <= 1'b1;
            state      <= FETCH_IDLE;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  // instruction register
  always_ff @(posedge clk) begin
    if (state == FETCH_WAIT && ifu_resp) begin
      inst <= ifu_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_pending <= 1'b0;
    end else if (ifu_req) begin
      fetch_pending <= 1'b1;
    end else if (ifu_resp) begin
      fetch_pending <= 1'b0;
    end
  end

  // one fetch in flight at a time
  a_single_fetch: assert property (
    @(posedge clk) disable iff (rst) ifu_req |-> !fetch_pending);

endmodule

// File: hdl/load_store_unit.sv
`timescale 1ns/100ps

module load_store_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  mem_start,
  input  cpu_pkg::inst_kind_e   kind,
  input  cpu_pkg::word_t        addr,
  input  cpu_pkg::word_t        store_data,
  input  cpu_pkg::byte_mask_t   wmask,
  input  cpu_pkg::access_size_t size,
  output logic                  mem_done,
  output cpu_pkg::word_t        load_data,
  output logic                  lsu_req,
  output cpu_pkg::word_t        lsu_addr,
  output logic                  lsu_wen,
  output cpu_pkg::word_t        lsu_wdata,
  output cpu_pkg::byte_mask_t   lsu_wmask,
  output cpu_pkg::access_size_t lsu_size,
  input  logic                  lsu_resp,
  input  cpu_pkg::word_t        lsu_rdata
);

  import cpu_pkg::*;

  typedef enum logic {LSU_IDLE, LSU_WAIT} lsu_state_e;

  lsu_state_e state;
  logic       is_store;
  word_t      rdata_shifted;

  assign is_store = (kind == KIND_SW) || (kind == KIND_SB);

  // addressed byte lands in bits [7:0]
  assign rdata_shifted = lsu_rdata >> {lsu_addr[1:0], 3'b000};

  // ====================
  // bus fsm
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= LSU_IDLE;
      lsu_req  <= 1'b0;
      lsu_wen  <= 1'b0;
      mem_done <= 1'b0;
    end else begin
      lsu_req  <= 1'b0;
      mem_done <= 1'b0;
      if (state == LSU_IDLE && mem_start) begin
        lsu_req <= 1'b1;
        lsu_wen <= is_store;
        state   <= LSU_WAIT;
      end else if (state == LSU_WAIT && lsu_resp) begin
        lsu_wen  <= 1'b0;
        mem_done <= 1'b1;
        state    <= LSU_IDLE;
      end
    end
  end

  // request payload and load result
  always_ff @(posedge clk) begin
    if (state == LSU_IDLE && mem_start) begin
      lsu_addr  <= addr;
      lsu_wmask <= wmask << addr[1:0];
      lsu_wdata <= store_data << {addr[1:0], 3'b000};
      lsu_size  <= size;
    end
    if (state == LSU_WAIT && lsu_resp) begin
      // byte size only comes from lbu on the read side
      load_data <= (lsu_size == 2'd0) ? {24'b0, rdata_shifted[7:0]} : rdata_shifted;
    end
  end

  a_write_mask: assert property (
    @(posedge clk) disable iff (rst) (lsu_req && lsu_wen) |-> (lsu_wmask != '0));

endmodule

// File: hdl/register_file.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module register_file (
  input  logic              clk,
  input  logic              wen,
  input  cpu_pkg::reg_idx_t waddr,
  input  cpu_pkg::word_t    wdata,
  input  cpu_pkg::reg_idx_t raddr_1,
  input  cpu_pkg::reg_idx_t raddr_2,
  output cpu_pkg::word_t    rdata_1,
  output cpu_pkg::word_t    rdata_2
);

  import cpu_pkg::*;

  // rv32e, x0..x15
  word_t regs [`CPU_REG_COUNT];

  always_ff @(posedge clk) begin
    if (wen && waddr[3:0] != 4'd0) begin
      regs[waddr[3:0]] <= wdata;
    end
  end

  // x0 hardwired to zero
  assign rdata_1 = (raddr_1[3:0] == 4'd0) ? '0 : regs[raddr_1[3:0]];
  assign rdata_2 = (raddr_2[3:0] == 4'd0) ? '0 : regs[raddr_2[3:0]];

endmodule

// File: hdl/retire_unit.sv
`timescale 1ns/100ps

module retire_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                inst_valid,
  input  cpu_pkg::inst_kind_e kind,
  input  cpu_pkg::word_t      pc,
  input  cpu_pkg::word_t      alu_out,
  input  cpu_pkg::word_t      load_data,
  input  logic                mem_done,
  output logic                mem_start,
  output logic                retire,
  output logic                reg_wen,
  output cpu_pkg::word_t      reg_wdata
);

  import cpu_pkg::*;

  typedef enum logic [1:0] {RET_IDLE, RET_MEM_WAIT, RET_DONE} retire_state_e;

  retire_state_e state;
  logic          is_load;
  logic          is_mem;
  logic          writes_reg;

  assign is_load    = (kind == KIND_LW) || (kind == KIND_LBU);
  assign is_mem     = is_load || (kind == KIND_SW) || (kind == KIND_SB);
  assign writes_reg = !(kind inside {KIND_SW, KIND_SB, KIND_NOP});

  // write-back select
  assign reg_wdata = (kind == KIND_JALR) ? pc + 32'd4 :
                     is_load             ? load_data  : alu_out;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= RET_IDLE;
      mem_start <= 1'b0;
      retire    <= 1'b0;
      reg_wen   <= 1'b0;
    end else begin
      mem_start <= 1'b0;
      retire    <= 1'b0;
      reg_wen   <= 1'b0;
      case (state)
        RET_IDLE: begin
          if (inst_valid && is_mem) begin
            mem_start <= 1'b1;
            state     <= RET_MEM_WAIT;
          end else if (inst_valid) begin
            retire  <= 1'b1;
            reg_wen <= writes_reg;
            state   <= RET_DONE;
          end
        end
        RET_MEM_WAIT: begin
          if (mem_done) begin
            retire  <= 1'b1;
            reg_wen <= writes_reg;
            state   <= RET_DONE;
          end
        end
        // inst_valid drops after retire, wait it out
        RET_DONE: state <= RET_IDLE;
        default:  state <= RET_IDLE;
      endcase
    end
  end

  a_retire_valid: assert property (
    @(posedge clk) disable iff (rst) retire |-> inst_valid);

endmodule

// File: sim/cpu_tb.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_tb;

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 8;
  localparam int INSTS_PER_TEST = 100;
  localparam int NUM_TESTS      = 4;
  // both buses at 6 cycles plus the fsm steps
  localparam int MAX_INST_CYCLES = 24;
  localparam int WATCHDOG_NS =
    (RESET_CYCLES + (INSTS_PER_TEST * NUM_TESTS + 1) * MAX_INST_CYCLES) * CLK_PERIOD;

  logic        clk;
  logic        rst;
  logic        ifu_req;
  logic [31:0] ifu_addr;
  logic        ifu_resp;
  logic [31:0] ifu_rdata;
  logic        lsu_req;
  logic [31:0] lsu_addr;
  logic        lsu_wen;
  logic [31:0] lsu_wdata;
  logic [3:0]  lsu_wmask;
  logic [1:0]  lsu_size;
  logic        lsu_resp;
  logic [31:0] lsu_rdata;

  int          seed;
  int          checks;
  int          errors;
  int          fetch_count;
  int          ifu_left;
  int          lsu_left;
  int          checks_before;
  int          errors_before;
  logic [31:0] ifu_next_data;
  logic [31:0] lsu_next_data;
  // isa model state
  logic [31:0] model_pc;
  logic [31:0] regs [16];
  logic [31:0] dmem [512];
  logic        exp_valid;
  logic [31:0] exp_addr;
  logic        exp_wen;
  logic [31:0] exp_wdata;
  logic [3:0]  exp_wmask;
  logic [1:0]  exp_size;

  cpu_top uut (
    .clk, .rst, .ifu_req, .ifu_addr, .ifu_resp, .ifu_rdata,
    .lsu_req, .lsu_addr, .lsu_wen, .lsu_wdata, .lsu_wmask, .lsu_size,
    .lsu_resp, .lsu_rdata
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("[FAIL] %s: got %08h, expected %08h", name, got, want);
    end
  endtask

  // one cycle in the first test, then 1 to 6
  task automatic draw_delay(output int cycles);
    cycles = 1;
    if (fetch_count > INSTS_PER_TEST) begin
      cycles = int'({$random(seed)} % 6) + 1;
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name,
             checks - checks_before, errors - errors_before);
    checks_before = checks;
    errors_before = errors;
  endtask

  // ====================
  // instruction generator and isa model
  // ====================
  task automatic issue_instruction(output logic [31:0] word);
    logic [31:0] rnd;
    logic [3:0]  rd;
    logic [3:0]  rs1;
    logic [3:0]  rs2;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic [1:0]  off;
    logic [4:0]  sh;
    logic [8:0]  widx;
    logic [31:0] result;
    logic [31:0] next_pc;
    logic        writes;
    int unsigned pick;

    rnd  = $random(seed);
    pick = {$random(seed)} % 17;
    rd   = rnd[3:0];
    rs1  = rnd[7:4];
    rs2  = rnd[11:8];
    imm  = rnd[23:12];
    // fill x1..x15 first so no register holds x
    if (fetch_count < 15) begin
      pick = 2;
      rd   = 4'(fetch_count + 1);
      rs1  = 4'd0;
    end
    writes  = 1'b1;
    result  = '0;
    next_pc = model_pc + 32'd4;
    // loads and stores use base x0 in the low 2 KB
    if (pick >= 6 && pick <= 15) begin
      imm[11] = 1'b0;
      if (pick == 6 || pick == 7 || (pick >= 10 && pick <= 12)) begin
        imm[1:0] = 2'b00;
      end
    end
    off  = imm[1:0];
    sh   = {off, 3'b000};
    widx = imm[10:2];
    case (pick)
      0, 1: begin
        word   = {7'b0, 1'b0, rs2, 1'b0, rs1, `CPU_F3_ADD, 1'b0, rd, `CPU_OPC_OP};
        result = regs[rs1] + regs[rs2];
      end
      2, 3: begin
        word   = {imm, 1'b0, rs1, `CPU_F3_ADD, 1'b0, rd, `CPU_OPC_OP_IMM};
        result = regs[rs1] + {{20{imm[11]}}, imm};
      end
      4: begin
        word   = {rnd[31:12], 1'b0, rd, `CPU_OPC_LUI};
        result = {rnd[31:12], 12'b0};
      end
      5: begin
        word    = {imm, 5'd0, 3'b000, 1'b0, rd, `CPU_OPC_JALR};
        result  = model_pc + 32'd4;
        next_pc = {{20{imm[11]}}, imm[11:1], 1'b0};
      end
      6, 7, 8, 9: begin
        f3        = (pick < 8) ? `CPU_F3_LW : `CPU_F3_LBU;
        word      = {imm, 5'd0, f3, 1'b0, rd, `CPU_OPC_LOAD};
        result    = (dmem[widx] >> sh) & ((pick < 8) ? 32'hffff_ffff : 32'h0000_00ff);
        exp_valid = 1'b1;
        exp_addr  = {20'b0, imm};
        exp_wen   = 1'b0;
        exp_size  = (pick < 8) ? 2'd2 : 2'd0;
      end
      10, 11, 12, 13, 14, 15: begin
        f3        = (pick < 13) ? `CPU_F3_SW : `CPU_F3_SB;
        word      = {imm[11:5], 1'b0, rs2, 5'd0, f3, imm[4:0], `CPU_OPC_STORE};
        writes    = 1'b0;
        exp_valid = 1'b1;
        exp_addr  = {20'b0, imm};
        exp_wen   = 1'b1;
        exp_wdata = regs[rs2] << sh;
        exp_wmask = ((pick < 13) ? 4'b1111 : 4'b0001) << off;
        exp_size  = (pick < 13) ? 2'd2 : 2'd0;
        if (pick < 13) begin
          dmem[widx] = regs[rs2];
        end else begin
          dmem[widx] = (dmem[widx] & ~(32'h0000_00ff << sh)) | ({24'b0, regs[rs2][7:0]} << sh);
        end
      end
      // system opcode, unknown to the core
      default: begin
        word   = {rnd[31:7], 7'b1110011};
        writes = 1'b0;
      end
    endcase
    if (writes && rd != 4'd0) begin
      regs[rd] = result;
    end
    model_pc = next_pc;
  endtask

  // ====================
  // bus responders
  // ====================
  always @(negedge clk) begin
    if (rst) begin
      check("ifu_req", {31'b0, ifu_req}, 32'd0);
      check("lsu_req", {31'b0, lsu_req}, 32'd0);
    end else begin
      ifu_resp = 1'b0;
      if (ifu_req && ifu_left > 0) begin
        errors++;
        $display("instruction request issued while a fetch was still outstanding");
      end
      if (ifu_left > 0) begin
        ifu_left--;
        if (ifu_left == 0) begin
          ifu_resp  = 1'b1;
          ifu_rdata = ifu_next_data;
        end
      end
      if (ifu_req) begin
        check("ifu_addr", ifu_addr, model_pc);
        if (exp_valid) begin
          errors++;
          $display("instruction retired without its data bus request");
          exp_valid = 1'b0;
        end
        issue_instruction(ifu_next_data);
        fetch_count++;
        draw_delay(ifu_left);
      end

      lsu_resp = 1'b0;
      if (lsu_req && lsu_left > 0) begin
        errors++;
        $display("data request issued while another one was still outstanding");
      end
      if (lsu_left > 0) begin
        lsu_left--;
        if (lsu_left == 0) begin
          lsu_resp  = 1'b1;
          lsu_rdata = lsu_next_data;
        end
      end
      if (lsu_req) begin
        if (!exp_valid) begin
          errors++;
          $display("data request from an instruction that has no memory access");
        end else begin
          check("lsu_addr", lsu_addr, exp_addr);
          check("lsu_wen", {31'b0, lsu_wen}, {31'b0, exp_wen});
          check("lsu_size", {30'b0, lsu_size}, {30'b0, exp_size});
          if (exp_wen) begin
            check("lsu_wmask", {28'b0, lsu_wmask}, {28'b0, exp_wmask});
            check("lsu_wdata", lsu_wdata, exp_wdata);
          end
          exp_valid = 1'b0;
        end
        lsu_next_data = dmem[lsu_addr[10:2]];
        draw_delay(lsu_left);
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the core stalled after %0d fetches", fetch_count);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    seed          = 32'ha988e097;
    checks        = 0;
    errors        = 0;
    checks_before = 0;
    errors_before = 0;
    fetch_count   = 0;
    ifu_left      = 0;
    lsu_left      = 0;
    exp_valid     = 1'b0;
    model_pc      = `CPU_RESET_PC;
    for (int i = 0; i < 16; i++) begin
      regs[i] = '0;
    end
    // every word differs, derived from its full index
    for (int i = 0; i < 512; i++) begin
      dmem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    end
    rst       = 1'b1;
    ifu_resp  = 1'b0;
    ifu_rdata = '0;
    lsu_resp  = 1'b0;
    lsu_rdata = '0;

    repeat (RESET_CYCLES) @(negedge clk);
    rst <= 1'b0;
    // boot fetch goes out in the first cycle
    @(negedge clk);
    check("ifu_req", {31'b0, ifu_req}, 32'd1);
    report_test(1, "reset and first fetch");

    for (int t = 1; t <= NUM_TESTS; t++) begin
      while (fetch_count <= t * INSTS_PER_TEST) begin
        @(posedge clk);
      end
      if (t == 1) begin
        report_test(t + 1, "instruction stream, one-cycle responses");
      end else begin
        report_test(t + 1, "instruction stream, random response delays");
      end
    end

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/load_store_unit.sv
hdl/retire_unit.sv
hdl/cpu_top.sv
sim/cpu_tb.sv
